// File: files.f
+incdir+source
source/controlUnitPkg.sv
source/phaseIf.sv
source/cycleSequencer.sv
source/controlDecoder.sv
source/controlUnit.sv
dv/controlUnit_asserts.sv
dv/controlUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  := Finished with errors

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "^$(FAIL_MSG)$$" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/controlUnitTb.sv
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlUnitTb;

   typedef struct {
      controlUnitPkg::opcodeT      opcode;
      controlUnitPkg::branchT      branchCode;
      logic [`CU_FLAG_WIDTH-1:0]   flags;
      int                          execLength;
      controlUnitPkg::aluFunctionT aluOp;      // Exe1 values
      controlUnitPkg::op2SelectT   op2Sel;
      logic                        regWe;
      controlUnitPkg::pcSelectT    pcSel;      // Last execute cycle
      logic                        cFlag;      // Carry after the instruction
   } rowT;

   logic                        Clock;
   logic                        nReset;
   logic [`CU_INSTR_WIDTH-1:0]  OpcodeCondIn;
   logic [`CU_FLAG_WIDTH-1:0]   Flags;
   controlUnitPkg::aluFunctionT AluOp;
   controlUnitPkg::op1SelectT   Op1Sel;
   controlUnitPkg::op2SelectT   Op2Sel;
   controlUnitPkg::immSelectT   ImmSel;
   controlUnitPkg::wdSelectT    WdSel;
   controlUnitPkg::pcSelectT    PcSel;
   controlUnitPkg::rs1SelectT   Rs1Sel;
   logic AluEn, AluWe, LrWe, PcWe, PcEn, IrWe, RegWe;
   logic MemEn, nWE, nOE, nME, ENB, ALE, CFlag;

   rowT  rows[$];
   int   seed = 83306;
   int   mismatches = 0;
   int   timeouts = 0;
   int   assertFailures = 0;
   logic carryModel = 1'b0;    // Reset clears the status register

   controlUnit dut0 (.*);

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      assert (actual === expected) else begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic addRow(input controlUnitPkg::opcodeT op, input controlUnitPkg::branchT br,
         input int len, input controlUnitPkg::aluFunctionT alu,
         input controlUnitPkg::op2SelectT op2, input logic regWe,
         input controlUnitPkg::pcSelectT pcSel, input logic loadsStatus);
      rowT         row;
      logic [31:0] rnd;
      rnd = $random(seed);
      row = '{op, br, rnd[`CU_FLAG_WIDTH-1:0], len, alu, op2, regWe, pcSel, 1'b0};
      if (loadsStatus)
         carryModel = row.flags[`CU_FLAG_C];
      row.cFlag = carryModel;                  // Others keep the old carry
      rows.push_back(row);
   endtask

   task automatic buildTable();
      addRow(controlUnitPkg::ADD, controlUnitPkg::BR, 1, controlUnitPkg::FnADD,
             controlUnitPkg::Op2Rd2, 1'b1, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::CMP, controlUnitPkg::BR, 1, controlUnitPkg::FnSUB,
             controlUnitPkg::Op2Rd2, 1'b0, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::LUI, controlUnitPkg::BR, 1, controlUnitPkg::FnIMM,
             controlUnitPkg::Op2Imm, 1'b1, controlUnitPkg::Pc1, 1'b0);
      addRow(controlUnitPkg::ADDI, controlUnitPkg::BR, 1, controlUnitPkg::FnADD,
             controlUnitPkg::Op2Imm, 1'b1, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::LDW, controlUnitPkg::BR, 5, controlUnitPkg::FnADD,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::Pc1, 1'b0);
      addRow(controlUnitPkg::XOR, controlUnitPkg::BR, 1, controlUnitPkg::FnXOR,
             controlUnitPkg::Op2Rd2, 1'b0, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::BRANCH, controlUnitPkg::JMP, 1, controlUnitPkg::FnADD,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::PcAluOut, 1'b0);
      addRow(controlUnitPkg::STW, controlUnitPkg::BR, 5, controlUnitPkg::FnADD,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::Pc1, 1'b0);
      addRow(controlUnitPkg::CMPI, controlUnitPkg::BR, 1, controlUnitPkg::FnSUB,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::BRANCH, controlUnitPkg::RET, 1, controlUnitPkg::FnNOP,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::PcSysbus, 1'b0);
      addRow(controlUnitPkg::NEG, controlUnitPkg::BR, 1, controlUnitPkg::FnNEG,
             controlUnitPkg::Op2Imm, 1'b0, controlUnitPkg::Pc1, 1'b1);
      addRow(controlUnitPkg::LLI, controlUnitPkg::BR, 1, controlUnitPkg::FnIMM,
             controlUnitPkg::Op2Imm, 1'b1, controlUnitPkg::Pc1, 1'b0);
   endtask

   // Fet1 strobes with the PC driven out as the address
   task automatic checkFetchStart();
      checkValue("ALE", 1, 32'(ALE));
      checkValue("nME", 1, 32'(nME));
      checkValue("nWE", 1, 32'(nWE));
      checkValue("nOE", 1, 32'(nOE));
      checkValue("PcEn", 1, 32'(PcEn));
      checkValue("RegWe", 0, 32'(RegWe));
      checkValue("PcWe", 0, 32'(PcWe));
      checkValue("IrWe", 0, 32'(IrWe));
      checkValue("MemEn", 0, 32'(MemEn));
      checkValue("AluWe", 0, 32'(AluWe));
      checkValue("LrWe", 0, 32'(LrWe));
      checkValue("AluEn", 0, 32'(AluEn));     // Everything else at its default
      checkValue("ENB", 0, 32'(ENB));
      checkValue("Op1Sel", 32'(controlUnitPkg::Op1Rd1), 32'(Op1Sel));
      checkValue("ImmSel", 32'(controlUnitPkg::ImmLong), 32'(ImmSel));
      checkValue("Rs1Sel", 32'(controlUnitPkg::Rs1Ra), 32'(Rs1Sel));
      checkValue("WdSel", 32'(controlUnitPkg::WdAlu), 32'(WdSel));
   endtask

   // Runs from the falling edge of one Fet1 to the falling edge of the next
   task automatic runInstruction(input rowT row);
      int                       fetchCycles;
      int                       execCycles;
      logic                     isRet;
      logic                     sawRegWe;
      logic                     lastPcWe;
      logic                     lastLrWe;
      logic                     lastRegWe;
      controlUnitPkg::pcSelectT lastPcSel;
      controlUnitPkg::wdSelectT lastWdSel;
      isRet = (row.opcode == controlUnitPkg::BRANCH) && (row.branchCode == controlUnitPkg::RET);
      sawRegWe = 1'b0;
      @(posedge Clock);
      #5;
      OpcodeCondIn = {row.opcode, row.branchCode};   // Held through execute
      Flags = row.flags;
      fetchCycles = 1;
      @(negedge Clock);
      while (!IrWe && fetchCycles < 8) begin
         checkValue("MemEn", 1, 32'(MemEn));
         @(negedge Clock);
         fetchCycles++;
      end
      if (!IrWe) begin
         timeouts++;
         $display("Timeout at %0t ns: IrWe never rose during fetch", $time);
         return;
      end
      checkValue("IrWe cycles after ALE", 3, fetchCycles);
      checkValue("MemEn", 1, 32'(MemEn));
      execCycles = 0;
      @(negedge Clock);
      while (!(ALE && PcEn) && execCycles < 12) begin
         execCycles++;
         checkValue("IrWe", 0, 32'(IrWe));
         if (execCycles == 1) begin
            checkValue("AluOp", 32'(row.aluOp), 32'(AluOp));
            checkValue("Op2Sel", 32'(row.op2Sel), 32'(Op2Sel));
            checkValue("RegWe", 32'(row.regWe), 32'(RegWe));
         end
         if (execCycles == 2 && row.execLength > 1)
            checkValue("ALE", 1, 32'(ALE));           // Data address phase
         sawRegWe |= RegWe;
         lastPcSel = PcSel;
         lastWdSel = WdSel;
         lastPcWe = PcWe;
         lastLrWe = LrWe;
         lastRegWe = RegWe;
         @(negedge Clock);
      end
      if (!(ALE && PcEn)) begin
         timeouts++;
         $display("Timeout at %0t ns: instruction never returned to fetch", $time);
         return;
      end
      checkValue("execute length", row.execLength, execCycles);
      checkValue("PcSel", 32'(row.pcSel), 32'(lastPcSel));
      checkValue("PcWe", 32'(!isRet), 32'(lastPcWe));
      checkValue("LrWe", 32'(isRet), 32'(lastLrWe));
      if (row.opcode == controlUnitPkg::LDW) begin
         checkValue("RegWe", 1, 32'(lastRegWe));
         checkValue("WdSel", 32'(controlUnitPkg::WdSys), 32'(lastWdSel));
      end
      if (row.opcode == controlUnitPkg::STW)
         checkValue("RegWe", 0, 32'(sawRegWe));
      checkFetchStart();
      checkValue("CFlag", 32'(row.cFlag), 32'(CFlag));
   endtask

   initial begin
      nReset = 1'b0;
      OpcodeCondIn = '0;
      Flags = '0;
      buildTable();
      @(negedge Clock);
      checkFetchStart();                                // Held in reset
      checkValue("CFlag", 0, 32'(CFlag));
      repeat (9) @(posedge Clock);
      #5;
      nReset = 1'b1;
      @(negedge Clock);
      checkFetchStart();
      checkValue("CFlag", 0, 32'(CFlag));
      foreach (rows[i]) begin
         if (timeouts == 0)
            runInstruction(rows[i]);
      end
      assertFailures = dut0.asserts0.failCount;
      $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               mismatches, timeouts, assertFailures);
      if (mismatches + timeouts + assertFailures == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: dv/controlUnit_asserts.sv
`timescale 1ns/1ps

module controlUnit_asserts (
   input logic                        Clock,
   input logic                        nReset,
   input logic                        IrWe,
   input logic                        ALE,
   input logic                        nOE,
   input logic                        MemEn,
   input controlUnitPkg::phaseT       majorPhase,
   input controlUnitPkg::executeStepT executeStep
);

   int failCount = 0;   // Failed assertions so far

   // Fet4 latches the instruction and Exe1 follows
   irWeThenExecute: assert property (@(posedge Clock) disable iff (!nReset)
      IrWe |=> (majorPhase == controlUnitPkg::Execute))
      else begin
         failCount++;
         $error("IrWe was not followed by an execute cycle");
      end

   noBusContention: assert property (@(posedge Clock) disable iff (!nReset)
      !(nOE && MemEn))
      else begin
         failCount++;
         $error("nOE and MemEn high together");
      end

   noLateAle: assert property (@(posedge Clock) disable iff (!nReset)
      (majorPhase == controlUnitPkg::Execute && executeStep inside
         {controlUnitPkg::Exe3, controlUnitPkg::Exe4, controlUnitPkg::Exe5}) |-> !ALE)
      else begin
         failCount++;
         $error("ALE asserted after the address phase");
      end

endmodule

bind controlUnit controlUnit_asserts asserts0 (
   .Clock       (Clock),
   .nReset      (nReset),
   .IrWe        (IrWe),
   .ALE         (ALE),
   .nOE         (nOE),
   .MemEn       (MemEn),
   .majorPhase  (phaseBus.majorPhase),
   .executeStep (phaseBus.executeStep)
);

// File: source/controlUnit.sv
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlUnit (
   input  logic                        Clock,
   input  logic                        nReset,
   input  logic [`CU_INSTR_WIDTH-1:0]  OpcodeCondIn,
   input  logic [`CU_FLAG_WIDTH-1:0]   Flags,
   output controlUnitPkg::aluFunctionT AluOp,
   output controlUnitPkg::op1SelectT   Op1Sel,
   output controlUnitPkg::op2SelectT   Op2Sel,
   output controlUnitPkg::immSelectT   ImmSel,
   output controlUnitPkg::wdSelectT    WdSel,
   output controlUnitPkg::pcSelectT    PcSel,
   output controlUnitPkg::rs1SelectT   Rs1Sel,
   output logic                        AluEn,
   output logic                        AluWe,
   output logic                        LrWe,
   output logic                        PcWe,
   output logic                        PcEn,
   output logic                        IrWe,
   output logic                        RegWe,
   output logic                        MemEn,
   output logic                        nWE,
   output logic                        nOE,
   output logic                        nME,
   output logic                        ENB,
   output logic                        ALE,
   output logic                        CFlag
);

   phaseIf phaseBus ();

   cycleSequencer seq0 (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .phase        (phaseBus.sequencer)
   );

   controlDecoder dec0 (
      .Clock  (Clock),
      .nReset (nReset),
      .Flags  (Flags),
      .phase  (phaseBus.decoder),
      .AluOp  (AluOp),
      .Op1Sel (Op1Sel),
      .Op2Sel (Op2Sel),
      .ImmSel (ImmSel),
      .WdSel  (WdSel),
      .PcSel  (PcSel),
      .Rs1Sel (Rs1Sel),
      .AluEn  (AluEn),
      .AluWe  (AluWe),
      .LrWe   (LrWe),
      .PcWe   (PcWe),
      .PcEn   (PcEn),
      .IrWe   (IrWe),
      .RegWe  (RegWe),
      .MemEn  (MemEn),
      .nWE    (nWE),
      .nOE    (nOE),
      .nME    (nME),
      .ENB    (ENB),
      .ALE    (ALE),
      .CFlag  (CFlag)
   );

endmodule

// File: source/controlDecoder.sv
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlDecoder (
   input  logic                            Clock,
   input  logic                            nReset,
   input  logic [`CU_FLAG_WIDTH-1:0]       Flags,
   phaseIf.decoder                         phase,
   output controlUnitPkg::aluFunctionT     AluOp,
   output controlUnitPkg::op1SelectT       Op1Sel,
   output controlUnitPkg::op2SelectT       Op2Sel,
   output controlUnitPkg::immSelectT       ImmSel,
   output controlUnitPkg::wdSelectT        WdSel,
   output controlUnitPkg::pcSelectT        PcSel,
   output controlUnitPkg::rs1SelectT       Rs1Sel,
   output logic                            AluEn,
   output logic                            AluWe,
   output logic                            LrWe,
   output logic                            PcWe,
   output logic                            PcEn,
   output logic                            IrWe,
   output logic                            RegWe,
   output logic                            MemEn,    // Pad direction
   output logic                            nWE,
   output logic                            nOE,
   output logic                            nME,
   output logic                            ENB,
   output logic                            ALE,
   output logic                            CFlag
);

   logic [`CU_FLAG_WIDTH-1:0] statusReg;
   logic                      statusWe;
   logic                      isLoad;

   assign isLoad = (phase.opcode == controlUnitPkg::LDW);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;                        // Capture ALU flags
      end
   end

   assign CFlag = statusReg[`CU_FLAG_C];

   always_comb begin
      AluOp    = controlUnitPkg::FnNOP;
      Op1Sel   = controlUnitPkg::Op1Rd1;
      Op2Sel   = controlUnitPkg::Op2Imm;
      ImmSel   = controlUnitPkg::ImmLong;
      WdSel    = controlUnitPkg::WdAlu;
      PcSel    = controlUnitPkg::Pc1;
      Rs1Sel   = controlUnitPkg::Rs1Ra;
      {AluEn, AluWe, LrWe, PcWe, PcEn, IrWe, RegWe} = '0;
      {MemEn, nWE, nOE, nME, ENB, ALE}              = '0;
      statusWe = 1'b0;

      if (phase.majorPhase == controlUnitPkg::Fetch) begin
         case (phase.fetchStep)
            controlUnitPkg::Fet1: begin
               {ALE, nME, nWE, nOE, PcEn} = '1;        // PC out as address
            end
            controlUnitPkg::Fet2: {nWE, MemEn} = '1;
            controlUnitPkg::Fet3: {MemEn, ENB, nWE} = '1;
            default:              {nME, nWE, MemEn, IrWe} = '1;
         endcase
      end else begin
         case (phase.executeStep)
            controlUnitPkg::Exe1: begin
               case (phase.opcode)
                  controlUnitPkg::LUI, controlUnitPkg::LLI: begin
                     AluOp = controlUnitPkg::FnIMM;
                     {nME, RegWe, AluEn, PcWe} = '1;
                  end
                  controlUnitPkg::LDW, controlUnitPkg::STW: begin
                     AluOp  = controlUnitPkg::FnADD;    // Base plus offset
                     ImmSel = controlUnitPkg::ImmShort;
                     {nME, AluEn, AluWe} = '1;
                  end
                  controlUnitPkg::BRANCH: begin
                     if (phase.branchCode == controlUnitPkg::RET) begin
                        PcSel = controlUnitPkg::PcSysbus;
                        {nME, LrWe, PcEn} = '1;
                     end else if (phase.branchCode == controlUnitPkg::JMP) begin
                        AluOp  = controlUnitPkg::FnADD;
                        ImmSel = controlUnitPkg::ImmShort;
                        PcSel  = controlUnitPkg::PcAluOut;
                        {nME, PcWe} = '1;
                     end
                  end
                  controlUnitPkg::PUSH_POP: ;               // Stack ops unimplemented
                  default: begin                            // ALU, shift and compare
                     {nME, PcEn, PcWe, statusWe} = '1;
                     case (phase.opcode)
                        controlUnitPkg::ADD, controlUnitPkg::ADDI, controlUnitPkg::ADDIB:
                           AluOp = controlUnitPkg::FnADD;
                        controlUnitPkg::ADC, controlUnitPkg::ADCI,
                        controlUnitPkg::SUC, controlUnitPkg::SUCI:
                           AluOp = controlUnitPkg::FnADC;
                        controlUnitPkg::SUB, controlUnitPkg::SUBI, controlUnitPkg::SUBIB,
                        controlUnitPkg::CMP, controlUnitPkg::CMPI:
                           AluOp = controlUnitPkg::FnSUB;
                        controlUnitPkg::NEG:  AluOp = controlUnitPkg::FnNEG;
                        controlUnitPkg::AND:  AluOp = controlUnitPkg::FnAND;
                        controlUnitPkg::OR:   AluOp = controlUnitPkg::FnOR;
                        controlUnitPkg::XOR:  AluOp = controlUnitPkg::FnXOR;
                        controlUnitPkg::NOT:  AluOp = controlUnitPkg::FnNOT;
                        controlUnitPkg::NAND: AluOp = controlUnitPkg::FnNAND;
                        controlUnitPkg::NOR:  AluOp = controlUnitPkg::FnNOR;
                        controlUnitPkg::LSL:  AluOp = controlUnitPkg::FnLSL;
                        controlUnitPkg::LSR:  AluOp = controlUnitPkg::FnLSR;
                        default: ;  // No arithmetic shift in the ALU, undefined codes
                     endcase
                     if (phase.opcode inside {controlUnitPkg::ADD, controlUnitPkg::SUB,
                           controlUnitPkg::CMP, controlUnitPkg::AND, controlUnitPkg::OR,
                           controlUnitPkg::XOR, controlUnitPkg::NAND, controlUnitPkg::NOR})
                        Op2Sel = controlUnitPkg::Op2Rd2;
                     if (phase.opcode inside {controlUnitPkg::ADDI, controlUnitPkg::SUBI,
                           controlUnitPkg::CMPI, controlUnitPkg::LSL, controlUnitPkg::LSR,
                           controlUnitPkg::ASR})
                        ImmSel = controlUnitPkg::ImmShort;
                     if (phase.opcode inside {controlUnitPkg::ADDIB, controlUnitPkg::SUBIB})
                        Rs1Sel = controlUnitPkg::Rs1Rd;     // Byte forms read Rd
                     // Result written back for arithmetic only
                     RegWe = phase.opcode inside {[controlUnitPkg::ADD:controlUnitPkg::SUCI]};
                  end
               endcase
            end
            controlUnitPkg::Exe2: begin
               AluOp  = controlUnitPkg::FnADD;
               ImmSel = controlUnitPkg::ImmShort;
               {nME, ALE, nWE, nOE, AluEn} = '1;       // Address latched off the bus
            end
            controlUnitPkg::Exe3: begin
               AluOp  = controlUnitPkg::FnMEM;
               Rs1Sel = controlUnitPkg::Rs1Rd;
               {nWE, AluWe, AluEn} = '1;
               MemEn  = isLoad;
               nOE    = !isLoad;                        // Store data driven out
            end
            controlUnitPkg::Exe4: begin
               {MemEn, ENB, nWE} = {3{isLoad}};
               {AluEn, nOE}      = {2{!isLoad}};
            end
            default: begin
               PcWe = 1'b1;                             // Done, next instruction
               nME  = 1'b1;
               if (isLoad) begin
                  WdSel = controlUnitPkg::WdSys;
                  {nWE, MemEn, RegWe} = '1;
               end else begin
                  {AluEn, nOE} = '1;
               end
            end
         endcase
      end
   end

endmodule

// File: source/cycleSequencer.sv
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module cycleSequencer (
   input  logic                       Clock,
   input  logic                       nReset,
   input  logic [`CU_INSTR_WIDTH-1:0] OpcodeCondIn,
   phaseIf.sequencer                  phase
);

   controlUnitPkg::phaseT       majorPhase;
   controlUnitPkg::fetchStepT   fetchStep;
   controlUnitPkg::executeStepT executeStep;
   controlUnitPkg::opcodeT      opcode;
   logic                        memOp;
   logic                        lastFetch;
   logic                        lastMemExec;

   // Opcode in the top bits, branch subcode in the bottom bits
   assign opcode = controlUnitPkg::opcodeT'(
      OpcodeCondIn[`CU_INSTR_WIDTH-1 -: `CU_OPCODE_WIDTH]);

   assign memOp = (opcode == controlUnitPkg::LDW) || (opcode == controlUnitPkg::STW);

   assign lastFetch = (fetchStep ==
      controlUnitPkg::fetchStepT'(`CU_FETCH_STEPS - 1));
   assign lastMemExec = (executeStep ==
      controlUnitPkg::executeStepT'(`CU_MEM_EXEC_STEPS - 1));

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         majorPhase  <= controlUnitPkg::Fetch;
         fetchStep   <= controlUnitPkg::Fet1;
         executeStep <= controlUnitPkg::Exe1;
      end else if (majorPhase == controlUnitPkg::Fetch) begin
         if (lastFetch) begin
            majorPhase  <= controlUnitPkg::Execute;   // Instruction latched in Fet4
            fetchStep   <= controlUnitPkg::Fet1;
            executeStep <= controlUnitPkg::Exe1;
         end else begin
            fetchStep <= controlUnitPkg::fetchStepT'(fetchStep + 1'b1);
         end
      end else begin
         // Only loads and stores stay past Exe1, anything else refetches
         if (memOp && !lastMemExec) begin
            executeStep <= controlUnitPkg::executeStepT'(executeStep + 1'b1);
         end else begin
            majorPhase  <= controlUnitPkg::Fetch;
            executeStep <= controlUnitPkg::Exe1;
         end
      end
   end

   assign phase.majorPhase  = majorPhase;
   assign phase.fetchStep   = fetchStep;
   assign phase.executeStep = executeStep;
   assign phase.opcode      = opcode;
   assign phase.branchCode  = controlUnitPkg::branchT'(OpcodeCondIn[`CU_COND_WIDTH-1:0]);

endmodule

// File: source/phaseIf.sv
`timescale 1ns/1ps

// Current step plus decoded instruction fields, valid every cycle
interface phaseIf;
   controlUnitPkg::phaseT       majorPhase;
   controlUnitPkg::fetchStepT   fetchStep;
   controlUnitPkg::executeStepT executeStep;
   controlUnitPkg::opcodeT      opcode;
   controlUnitPkg::branchT      branchCode;

   modport sequencer (
      output majorPhase,
      output fetchStep,
      output executeStep,
      output opcode,
      output branchCode
   );

   modport decoder (
      input majorPhase,
      input fetchStep,
      input executeStep,
      input opcode,
      input branchCode
   );
endinterface

// File: source/controlUnitPkg.sv
`include "controlUnit_config.svh"

package controlUnitPkg;

   // Top five bits of the instruction byte
   typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
      ADD, ADDI, ADDIB, ADC, ADCI,
      SUB, SUBI, SUBIB, SUC, SUCI,
      CMP, CMPI,
      AND, OR, XOR, NOT, NAND, NOR,
      LSL, LSR, ASR,
      NEG,
      LUI, LLI,
      LDW, STW,
      BRANCH,       // Subcode in the low bits
      PUSH_POP
   } opcodeT;

   typedef enum logic [`CU_COND_WIDTH-1:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchT;

   typedef enum logic [3:0] {
      FnNOP,
      FnADD,
      FnADC,
      FnSUB,
      FnNEG,
      FnAND,
      FnOR,
      FnXOR,
      FnNOT,
      FnNAND,
      FnNOR,
      FnLSL,
      FnLSR,
      FnIMM,        // Immediate passthrough
      FnMEM         // Operand 1 passthrough for stores and loads
   } aluFunctionT;

   typedef enum logic {Op1Rd1} op1SelectT;
   typedef enum logic {Op2Imm, Op2Rd2} op2SelectT;
   typedef enum logic {WdAlu, WdSys} wdSelectT;
   typedef enum logic {ImmLong, ImmShort} immSelectT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelectT;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1SelectT;

   // Sequencer state
   typedef enum logic {Fetch, Execute} phaseT;

   typedef enum logic [$clog2(`CU_FETCH_STEPS)-1:0] {
      Fet1, Fet2, Fet3, Fet4
   } fetchStepT;

   typedef enum logic [$clog2(`CU_MEM_EXEC_STEPS)-1:0] {
      Exe1, Exe2, Exe3, Exe4, Exe5
   } executeStepT;

endpackage

// File: source/controlUnit_config.svh
`ifndef CONTROLUNIT_CONFIG_SVH
`define CONTROLUNIT_CONFIG_SVH

// Instruction word layout
`define CU_OPCODE_WIDTH 5
`define CU_COND_WIDTH 3
`define CU_INSTR_WIDTH 8

// ALU status flags, carry in bit 0
`define CU_FLAG_WIDTH 4
`define CU_FLAG_C 0

// Sequencer step counts
`define CU_FETCH_STEPS 4
`define CU_MEM_EXEC_STEPS 5

`endif
